//--- common/LcdPkg.sv
// LCD content package, with character patterns and the host write format
`default_nettype none

package LcdPkg;

	// Characters on the panel, 0 is the rightmost
	localparam int CHARACTERS = 8;

	// Index width for addressing one character
	localparam int INDEX_W = $clog2(CHARACTERS);

	// One character, bit b is segment a..p without o
	// Bit 0 = a, bit 13 = n, bit 14 = p
	typedef logic [14:0] segmentsT;

	// Host write, one character per handshake
	typedef struct packed {
		logic [INDEX_W-1:0] index;	// Target character
		segmentsT           segments;	// Raw pattern, 1 = lit
	} characterWriteT;

	// Whole panel content
	typedef segmentsT [CHARACTERS-1:0] displayT;

endpackage

`default_nettype wire

//--- common/LcdDrivePkg.sv
// LCD drive package, with voltage levels, COM phases and pin counts
`default_nettype none

package LcdDrivePkg;

	localparam int COMS      = 4;	// 1/4 duty
	localparam int SEG_LINES = 32;	// Four per character
	localparam int PINS      = COMS + SEG_LINES;

	// Voltage in thirds of the supply, 1/3 bias
	typedef logic [1:0] levelT;

	// One drive phase
	// Order is com0..com3 high, then com0..com3 low
	typedef struct packed {
		logic [1:0] com;	// Active COM line
		logic       low;	// 0 = high half, 1 = low half
	} phaseT;

	// Level per pin, index 0 = pin 1
	// Pins 1..4 are COM 0..3, pin 5+s is segment line s
	typedef levelT [PINS-1:0] pinLevelsT;

endpackage

`default_nettype wire

//--- hdl/StrobeGenerator.sv
// Periodic strobe, one clock wide, every PERIOD_US microseconds
`timescale 1ns/1ps
`default_nettype none

module StrobeGenerator #(
	parameter int CLOCK_HZ  = 10_000_000,
	parameter int PERIOD_US = 10
)(
	input  wire  Clock,
	input  wire  Reset,
	output logic Strobe_o
);

	// Clocks per period, never below one
	localparam longint RAW_CLOCKS    = longint'(CLOCK_HZ) * PERIOD_US / 1_000_000;
	localparam int     PERIOD_CLOCKS = (RAW_CLOCKS < 1) ? 1 : int'(RAW_CLOCKS);
	localparam int     COUNT_W       = (PERIOD_CLOCKS > 1) ? $clog2(PERIOD_CLOCKS) : 1;
	localparam logic [COUNT_W-1:0] RELOAD = COUNT_W'(PERIOD_CLOCKS - 1);

	logic [COUNT_W-1:0] Count;	// Clocks left until the strobe

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset)
			Count <= RELOAD;	// Full period before first strobe
		else if (Count == '0)
			Count <= RELOAD;	// Terminal count
		else
			Count <= Count - 1'b1;
	end

	assign Strobe_o = (Count == '0);	// High for the terminal clock only

endmodule

`default_nettype wire

//--- lcd/CharacterStore.sv
// Character store with four-phase write port and frame-synchronous double buffer
`timescale 1ns/1ps
`default_nettype none

module CharacterStore (
	input  wire                    Clock,
	input  wire                    Reset,

	// Host write port, four-phase req/ack
	input  wire                    WriteReq_i,
	input  wire LcdPkg::characterWriteT WriteData_i,
	output logic                   WriteAck_o,

	// Frame timing from the sequencer
	input  wire                    FrameStart_i,

	// Content shown in the current frame
	output LcdPkg::displayT        Display_o
);

	import LcdPkg::*;

	displayT Shadow;	// Host side bank

	logic Accept;	// New request seen
	logic Release;	// Host dropped its request

	assign Accept  = WriteReq_i && !WriteAck_o;
	assign Release = !WriteReq_i && WriteAck_o;

	// Acknowledge side of the handshake
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset)
			WriteAck_o <= 1'b0;
		else if (Accept)
			WriteAck_o <= 1'b1;	// Held until req falls
		else if (Release)
			WriteAck_o <= 1'b0;
	end

	// Shadow bank, one character per accepted write
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset)
			Shadow <= '0;	// Blank panel
		else if (Accept)
			Shadow[WriteData_i.index] <= WriteData_i.segments;
	end

	// Active bank only changes between frames
	// A write on the same edge waits for the next frame
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset)
			Display_o <= '0;
		else if (FrameStart_i)
			Display_o <= Shadow;	// Whole bank at once
	end

endmodule

`default_nettype wire

//--- lcd/PhaseSequencer.sv
// COM phase sequencer, eight phases per frame with a frame start pulse
`timescale 1ns/1ps
`default_nettype none

module PhaseSequencer #(
	parameter int CLOCK_HZ = 10_000_000,
	parameter int PHASE_US = 10
)(
	input  wire                Clock,
	input  wire                Reset,
	output LcdDrivePkg::phaseT Phase_o,
	output logic               FrameStart_o
);

	import LcdDrivePkg::*;

	localparam int COM_W = $clog2(COMS);

	logic             Strobe;	// End of current phase
	logic [COM_W:0]   Step;	// {low, com}, com counts fastest

	StrobeGenerator #(
		.CLOCK_HZ  (CLOCK_HZ),
		.PERIOD_US (PHASE_US)
	) i_StrobeGenerator (
		.Clock    (Clock),
		.Reset    (Reset),
		.Strobe_o (Strobe)
	);

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset)
			Step <= '0;	// com0 high
		else if (Strobe)
			Step <= Step + 1'b1;	// Wraps after com3 low
	end

	assign Phase_o = '{com: Step[COM_W-1:0], low: Step[COM_W]};

	// Same edge as the wrap to com0 high
	assign FrameStart_o = Strobe && (Step == '1);

endmodule

`default_nettype wire

//--- lcd/LevelMapper.sv
// Level mapper, turns the drive phase and the characters into pin levels
`timescale 1ns/1ps
`default_nettype none

module LevelMapper (
	input  wire LcdDrivePkg::phaseT Phase_i,
	input  wire LcdPkg::displayT    Display_i,
	output LcdDrivePkg::pinLevelsT  Levels_o
);

	import LcdPkg::*;
	import LcdDrivePkg::*;

	localparam int LINES_PER_CHAR = SEG_LINES / CHARACTERS;
	localparam int SEGMENT_BITS   = $bits(segmentsT);

	levelT ComActive;
	levelT ComIdle;
	levelT SegLit;
	levelT SegUnlit;

	// High half 3/1/0/2, low half mirrors it
	assign ComActive = Phase_i.low ? levelT'(0) : levelT'(3);
	assign ComIdle   = Phase_i.low ? levelT'(2) : levelT'(1);
	assign SegLit    = Phase_i.low ? levelT'(3) : levelT'(0);
	assign SegUnlit  = Phase_i.low ? levelT'(1) : levelT'(2);

	// COM pins 1..4
	for (genvar m = 0; m < COMS; m++) begin : gCom
		assign Levels_o[m] = (Phase_i.com == m) ? ComActive : ComIdle;
	end

	// Segment pins 5..36
	for (genvar s = 0; s < SEG_LINES; s++) begin : gSegLine
		localparam int CHAR = s / LINES_PER_CHAR;	// Owning character
		localparam int ROW  = s % LINES_PER_CHAR;	// b mod 4

		logic [COMS-1:0] Cells;	// Segment bit seen by each COM

		for (genvar m = 0; m < COMS; m++) begin : gCell
			if (LINES_PER_CHAR * m + ROW < SEGMENT_BITS) begin : gUsed
				assign Cells[m] = Display_i[CHAR][LINES_PER_CHAR * m + ROW];
			end else begin : gUnused
				assign Cells[m] = 1'b0;	// No glass here, always off
			end
		end

		assign Levels_o[COMS + s] = Cells[Phase_i.com] ? SegLit : SegUnlit;
	end

endmodule

`default_nettype wire

//--- lcd/LevelPwm.sv
// PWM output stage, level 0..3 becomes a duty of 0..3 thirds on each pin
`timescale 1ns/1ps
`default_nettype none

module LevelPwm (
	input  wire                      Clock,
	input  wire                      Reset,
	input  wire LcdDrivePkg::pinLevelsT Levels_i,
	output logic [LcdDrivePkg::PINS:1] Pin_o
);

	import LcdDrivePkg::*;

	levelT Count;	// Runs 0, 1, 2

	// Three-clock frame fixed by 1/3 bias
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset)
			Count <= '0;
		else if (Count == levelT'(2))
			Count <= '0;
		else
			Count <= Count + 1'b1;
	end

	// Level 3 stays high, level 0 stays low
	// Registered so the RC filters see clean edges
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			Pin_o <= '0;
		end else begin
			for (int p = 0; p < PINS; p++) begin
				Pin_o[p + 1] <= (Count < Levels_i[p]);
			end
		end
	end

endmodule

`default_nettype wire

//--- lcd/Lcd.sv
// 8-character 15-segment LCD driver, 1/4 duty and 1/3 bias with PWM outputs
`timescale 1ns/1ps
`default_nettype none

module Lcd #(
	parameter int CLOCK_HZ = 10_000_000,
	parameter int PHASE_US = 10	// Length of one of the eight phases
)(
	input  wire                         Clock,
	input  wire                         Reset,

	// Host write port
	input  wire                         WriteReq_i,
	input  wire LcdPkg::characterWriteT WriteData_i,
	output logic                        WriteAck_o,

	// To panel pins through an RC filter each
	output logic [LcdDrivePkg::PINS:1]  Pin_o
);

	import LcdPkg::*;
	import LcdDrivePkg::*;

	logic      FrameStart;	// Copy shadow to active
	phaseT     Phase;	// Current COM and half
	displayT   Display;	// Frame-stable content
	pinLevelsT Levels;	// Target level per pin

	CharacterStore i_CharacterStore (
		.Clock        (Clock),
		.Reset        (Reset),
		.WriteReq_i   (WriteReq_i),
		.WriteData_i  (WriteData_i),
		.WriteAck_o   (WriteAck_o),
		.FrameStart_i (FrameStart),
		.Display_o    (Display)
	);

	PhaseSequencer #(
		.CLOCK_HZ (CLOCK_HZ),
		.PHASE_US (PHASE_US)
	) i_PhaseSequencer (
		.Clock        (Clock),
		.Reset        (Reset),
		.Phase_o      (Phase),
		.FrameStart_o (FrameStart)
	);

	LevelMapper i_LevelMapper (
		.Phase_i   (Phase),
		.Display_i (Display),
		.Levels_o  (Levels)
	);

	LevelPwm i_LevelPwm (
		.Clock    (Clock),
		.Reset    (Reset),
		.Levels_i (Levels),
		.Pin_o    (Pin_o)
	);

endmodule

`default_nettype wire

//--- tests/LcdTb.sv
// Directed testbench for the LCD driver write port and pin drive levels
`timescale 1ns/1ps
`default_nettype none

module LcdTb;

	import LcdPkg::*;
	import LcdDrivePkg::*;

	localparam int CLOCK_PERIOD     = 100;	// ns
	localparam int RESET_CYCLES     = 8;
	localparam int PHASE_CLOCKS     = 30;	// 3 us per phase at 10 MHz
	localparam int WINDOW_START     = 10;	// Sample clocks 10..12 of a phase
	localparam int HANDSHAKE_CLOCKS = 8;	// Max wait per ack edge
	localparam int SEGMENT_CHAR     = 5;	// Character used for single segments
	localparam int TOTAL_PHASES     = 2 * 8 + 15 * 16 + 3 * 8 + 2 * 8;
	localparam int WATCHDOG_CLOCKS  = RESET_CYCLES + TOTAL_PHASES * PHASE_CLOCKS + 200;

	logic                Clock;
	logic                Reset;
	logic                WriteReq_i;
	characterWriteT      WriteData_i;
	logic                WriteAck_o;
	logic [PINS:1]       Pin_o;

	int          cycle;	// Clocks since reset release
	logic [31:0] rngState = 32'd72392;
	logic [14:0] shadowRef [CHARACTERS];	// Acknowledged writes
	logic [14:0] activeRef [CHARACTERS];	// Content of the current frame

	Lcd #(
		.CLOCK_HZ (10_000_000),
		.PHASE_US (3)
	) i_Lcd (
		.Clock       (Clock),
		.Reset       (Reset),
		.WriteReq_i  (WriteReq_i),
		.WriteData_i (WriteData_i),
		.WriteAck_o  (WriteAck_o),
		.Pin_o       (Pin_o)
	);

	initial begin
		Clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) Clock = ~Clock;
	end

	always @(posedge Clock or negedge Reset) begin
		if (!Reset)
			cycle <= 0;
		else
			cycle <= cycle + 1;	// Phase k owns pins from clock 30k+1
	end

	initial begin
		#(WATCHDOG_CLOCKS * CLOCK_PERIOD);
		failRun("Watchdog expired before the tests finished");
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic checkEqual(input string name, input logic [71:0] actual,
			input logic [71:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			failRun("Value mismatch");
		end
	endtask

	// Expected pin levels for one phase of the current frame
	function automatic pinLevelsT expectedLevels(input int com, input bit low);
		pinLevelsT lv;
		int        bitIdx;
		logic      lit;
		for (int m = 0; m < COMS; m++) begin
			if (m == com)
				lv[m] = low ? 2'd0 : 2'd3;	// Active COM
			else
				lv[m] = low ? 2'd2 : 2'd1;
		end
		for (int s = 0; s < SEG_LINES; s++) begin
			bitIdx = 4 * com + s % 4;	// Bit seen by this COM
			lit = (bitIdx < 15) ? activeRef[s / 4][bitIdx] : 1'b0;	// No cell for bit 15
			lv[COMS + s] = lit ? (low ? 2'd3 : 2'd0) : (low ? 2'd1 : 2'd2);
		end
		return lv;
	endfunction

	// High cycles per pin over three clocks
	task automatic sampleLevels(output pinLevelsT lv);
		lv = '0;
		repeat (3) begin
			@(negedge Clock);
			for (int p = 0; p < PINS; p++)
				lv[p] = lv[p] + levelT'(Pin_o[p + 1]);
		end
	endtask

	task automatic nextWindow(output pinLevelsT lv, output int index);
		do begin
			@(negedge Clock);
		end while (cycle % PHASE_CLOCKS != WINDOW_START - 1);
		sampleLevels(lv);
		index = cycle / PHASE_CLOCKS;	// Phases since reset
	endtask

	// Phase from the COM pins only
	task automatic identifyPhase(input pinLevelsT lv, output int com, output bit low);
		int counts [4];
		counts = '{default: 0};
		com = 0;
		for (int m = 0; m < COMS; m++) begin
			counts[lv[m]]++;
			if (lv[m] == 2'd3 || lv[m] == 2'd0)
				com = m;	// Active level of either half
		end
		if (counts[3] == 1 && counts[1] == 3)
			low = 1'b0;
		else if (counts[0] == 1 && counts[2] == 3)
			low = 1'b1;
		else
			failRun("COM pins show no valid drive phase");
	endtask

	task automatic checkWindow(output int index);
		pinLevelsT lv;
		int        com;
		bit        low;
		nextWindow(lv, index);
		if (index % 8 == 0)
			activeRef = shadowRef;	// Frame start copies the shadow bank
		identifyPhase(lv, com, low);
		checkEqual("phase.com", com, index % 4);
		checkEqual("phase.low", low, (index % 8) >= 4);
		checkEqual("Pin_o levels", lv, expectedLevels(com, low));
	endtask

	// Up to the next com0 high, then a whole frame
	task automatic checkFrame();
		int index;
		do begin
			checkWindow(index);
		end while (index % 8 != 0);
		repeat (7) checkWindow(index);
	endtask

	task automatic writeChar(input int index, input logic [14:0] segments, input int holdClocks);
		int waited;
		checkEqual("WriteAck_o", WriteAck_o, 0);
		WriteData_i.index = 3'(index);
		WriteData_i.segments = segments;
		WriteReq_i = 1'b1;
		waited = 0;
		while (!WriteAck_o) begin
			@(negedge Clock);
			waited++;
			if (waited > HANDSHAKE_CLOCKS)
				failRun("WriteAck_o did not rise while WriteReq_i was high");
		end
		repeat (holdClocks) begin
			@(negedge Clock);
			checkEqual("WriteAck_o", WriteAck_o, 1);	// Held while req stays high
		end
		WriteReq_i = 1'b0;
		waited = 0;
		while (WriteAck_o) begin
			@(negedge Clock);
			waited++;
			if (waited > HANDSHAKE_CLOCKS)
				failRun("WriteAck_o did not fall after WriteReq_i dropped");
		end
		shadowRef[index] = segments;
	endtask

	task automatic checkResetState();
		pinLevelsT lv;
		repeat (RESET_CYCLES) begin
			@(negedge Clock);
			checkEqual("WriteAck_o", WriteAck_o, 0);
			checkEqual("Pin_o", Pin_o, '0);
		end
		Reset = 1'b1;
		sampleLevels(lv);	// First clocks after reset
		checkEqual("WriteAck_o", WriteAck_o, 0);
		checkEqual("Pin_o levels", lv, expectedLevels(0, 1'b0));
	endtask

	task automatic exerciseHandshake();
		writeChar(0, 15'h0000, 3);	// Long request hold with a blank pattern
		writeChar(7, 15'h0000, 0);
	endtask

	task automatic singleSegments();
		for (int b = 0; b < 15; b++) begin
			writeChar(SEGMENT_CHAR, 15'(1) << b, 0);
			checkFrame();
		end
		writeChar(SEGMENT_CHAR, 15'h0000, 0);
	endtask

	task automatic randomPatterns();
		int index;
		do begin
			checkWindow(index);
		end while (index % 8 != 0);
		for (int c = 0; c < CHARACTERS; c++) begin
			rngState = xorshift(rngState);
			writeChar(c, rngState[14:0], 0);
		end
		checkFrame();
	endtask

	task automatic frameLatching();
		int          index;
		int          target;
		logic [14:0] pattern;
		do begin
			checkWindow(index);
		end while (index % 8 != 1);
		rngState = xorshift(rngState);
		target = int'(rngState[2:0]);
		pattern = ~activeRef[target];	// Every cell of the character changes
		writeChar(target, pattern, 0);
		do begin
			checkWindow(index);	// Old content until com0 high
		end while (index % 8 != 0);
	endtask

	initial begin
		Reset = 1'b0;
		WriteReq_i = 1'b0;
		WriteData_i = '0;
		foreach (shadowRef[c]) begin
			shadowRef[c] = '0;
			activeRef[c] = '0;
		end
		checkResetState();
		exerciseHandshake();
		checkFrame();
		checkFrame();
		singleSegments();
		randomPatterns();
		frameLatching();
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
common/LcdPkg.sv
common/LcdDrivePkg.sv
hdl/StrobeGenerator.sv
lcd/CharacterStore.sv
lcd/PhaseSequencer.sv
lcd/LevelMapper.sv
lcd/LevelPwm.sv
lcd/Lcd.sv
tests/LcdTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the LCD driver testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f verilog.f --top-module LcdTb -o LcdTbSim \
	&& ./obj_dir/LcdTbSim | tee sim.log

grep -qsx "All tests passed" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
